// File: sources.f
+incdir+.
nebula_pkg.sv
wb_decoder.sv
team_slot.sv
gpio_control.sv
wb_sram.sv
nebula_top.sv
tb_nebula.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fabric testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_nebula \
    -f sources.f \
    -o sim_nebula

sim_output=$(./obj_dir/sim_nebula)
echo "$sim_output"

if grep -qx "TEST RESULT: PASS" <<< "$sim_output"; then
    exit 0
fi
exit 1

// File: tb_nebula.sv
// Directed testbench for the multi-project fabric
// Drives the host Wishbone port and checks SRAM, team slots and pin routing
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module tb_nebula;

    localparam int          NT          = `NEBULA_NUM_TEAMS;
    localparam int          GW          = `NEBULA_GPIO_W;
    localparam int          ACK_TIMEOUT = 20;
    localparam logic [63:0] PIN_MASK    = (64'd1 << GW) - 64'd1;

    logic              wb_clk;
    logic              rst;
    logic              wbs_cyc;
    logic              wbs_stb;
    logic              wbs_we;
    nebula_pkg::sel_t  wbs_sel;
    nebula_pkg::word_t wbs_adr;
    nebula_pkg::word_t wbs_dat_w;
    logic              wbs_ack;
    nebula_pkg::word_t wbs_dat_r;
    nebula_pkg::pins_t io_out;
    nebula_pkg::pins_t io_oeb;
    int                error_count;
    int                check_count;
    logic [31:0]       rand_word;

    nebula_top i_dut (
        .wb_clk_i  (wb_clk),
        .rst_i     (rst),
        .wbs_cyc_i (wbs_cyc),
        .wbs_stb_i (wbs_stb),
        .wbs_we_i  (wbs_we),
        .wbs_sel_i (wbs_sel),
        .wbs_adr_i (wbs_adr),
        .wbs_dat_i (wbs_dat_w),
        .wbs_ack_o (wbs_ack),
        .wbs_dat_o (wbs_dat_r),
        .io_out_o  (io_out),
        .io_oeb_o  (io_oeb)
    );

    initial begin
        wb_clk = 1'b0;
        forever #50 wb_clk = ~wb_clk; // 100 ns period
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] team_addr(input int slot, input nebula_pkg::team_reg_e r);
        return `NEBULA_TEAM_BASE + 32'(slot) * `NEBULA_TEAM_STRIDE + {28'd0, r, 2'b00};
    endfunction

    function automatic logic [31:0] sram_addr(input int index);
        return `NEBULA_SRAM_BASE + 32'(index * 4);
    endfunction

    // Byte lanes with their select bit set take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Pins above bit 31 have no byte lane and stay released
    function automatic logic [63:0] oeb_pins(input logic [31:0] v);
        return (PIN_MASK & ~64'h0000_0000_FFFF_FFFF) | 64'(v);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel, output logic [31:0] rdat);
        int   waited;
        logic acked;
        @(posedge wb_clk);
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        wbs_we    <= we;
        wbs_adr   <= adr;
        wbs_dat_w <= wdat;
        wbs_sel   <= sel;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        while (!acked && waited < ACK_TIMEOUT) begin
            @(negedge wb_clk);   // Sample away from the driving edge
            waited++;
            if (wbs_ack) begin
                acked = 1'b1;
                rdat  = wbs_dat_r;
            end
        end
        if (!acked) begin
            error_count++;
            $display("ERROR: no ack from address %h after %0d cycles", adr, ACK_TIMEOUT);
        end
        @(posedge wb_clk);
        wbs_cyc <= 1'b0;
        wbs_stb <= 1'b0;
        wbs_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] ignored_rdat;
        wb_cycle(1'b1, adr, dat, sel, ignored_rdat);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
        wb_cycle(1'b0, adr, 32'd0, 4'hF, rdat);
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        @(negedge wb_clk);
        check_value("reset io_oeb", PIN_MASK, 64'(io_oeb));
        check_value("reset io_out", 64'd0, 64'(io_out));
        wb_read(`NEBULA_GPIO_BASE, rd);
        check_value("reset owner", 64'(NT), 64'(rd));
        for (int n = 0; n < NT; n++) begin
            wb_read(team_addr(n, nebula_pkg::REG_OUT), rd);
            check_value($sformatf("reset slot %0d out", n), 64'd0, 64'(rd));
        end
    endtask

    task automatic test_sram();
        logic [31:0] shadow [6];
        logic [31:0] rd;
        for (int k = 0; k < 6; k++) begin
            rand_word = lcg_step(rand_word);
            shadow[k] = rand_word;
            wb_write(sram_addr(k * 51), rand_word, 4'hF); // Spread from word 0 to 255
        end
        for (int k = 0; k < 6; k++) begin
            wb_read(sram_addr(k * 51), rd);
            check_value($sformatf("sram word %0d", k * 51), 64'(shadow[k]), 64'(rd));
        end
        for (int k = 0; k < 6; k++) begin
            rand_word = lcg_step(rand_word);
            shadow[k] = merge_bytes(shadow[k], rand_word, 4'(k + 1));
            wb_write(sram_addr(k * 51), rand_word, 4'(k + 1));
            wb_read(sram_addr(k * 51), rd);
            check_value($sformatf("sram bytes %0d", k * 51), 64'(shadow[k]), 64'(rd));
        end
    endtask

    task automatic test_team_slots();
        logic [31:0] out_v;
        logic [31:0] oeb_v;
        logic [31:0] id_v;
        logic [31:0] rd;
        for (int n = 0; n < NT; n++) begin
            id_v = `NEBULA_TEAM_ID_TAG | 32'(n);
            wb_read(team_addr(n, nebula_pkg::REG_ID), rd);
            check_value($sformatf("slot %0d id", n), 64'(id_v), 64'(rd));
            rand_word = lcg_step(rand_word);
            out_v     = rand_word;
            rand_word = lcg_step(rand_word);
            oeb_v     = rand_word;
            wb_write(team_addr(n, nebula_pkg::REG_OUT), out_v, 4'hF);
            wb_write(team_addr(n, nebula_pkg::REG_OEB), oeb_v, 4'hF);
            wb_read(team_addr(n, nebula_pkg::REG_OUT), rd);
            check_value($sformatf("slot %0d out", n), 64'(out_v) & PIN_MASK, 64'(rd));
            wb_read(team_addr(n, nebula_pkg::REG_OEB), rd);
            check_value($sformatf("slot %0d oeb", n), 64'(oeb_v) & PIN_MASK, 64'(rd));
            // Identity is read-only and the pin registers must hold
            wb_write(team_addr(n, nebula_pkg::REG_ID), ~id_v, 4'hF);
            wb_read(team_addr(n, nebula_pkg::REG_ID), rd);
            check_value($sformatf("slot %0d id write", n), 64'(id_v), 64'(rd));
            wb_read(team_addr(n, nebula_pkg::REG_OUT), rd);
            check_value($sformatf("slot %0d out after id", n), 64'(out_v), 64'(rd));
            wb_read(team_addr(n, nebula_pkg::REG_OEB), rd);
            check_value($sformatf("slot %0d oeb after id", n), 64'(oeb_v), 64'(rd));
        end
    endtask

    task automatic test_gpio_routing();
        logic [31:0] out_v [NT];
        logic [31:0] oeb_v [NT];
        logic [31:0] rd;
        for (int n = 0; n < NT; n++) begin
            rand_word = lcg_step(rand_word);
            out_v[n]  = rand_word;
            rand_word = lcg_step(rand_word);
            oeb_v[n]  = rand_word;
            wb_write(team_addr(n, nebula_pkg::REG_OUT), out_v[n], 4'hF);
            wb_write(team_addr(n, nebula_pkg::REG_OEB), oeb_v[n], 4'hF);
        end
        for (int n = 0; n < NT; n++) begin
            wb_write(`NEBULA_GPIO_BASE, 32'(n), 4'hF);
            @(negedge wb_clk);
            check_value($sformatf("owner %0d io_out", n), 64'(out_v[n]), 64'(io_out));
            check_value($sformatf("owner %0d io_oeb", n), oeb_pins(oeb_v[n]), 64'(io_oeb));
            wb_read(`NEBULA_GPIO_BASE, rd);
            check_value($sformatf("owner %0d readback", n), 64'(n), 64'(rd));
        end
        for (int v = NT; v < NT + 3; v++) begin
            wb_write(`NEBULA_GPIO_BASE, 32'(v), 4'hF);
            @(negedge wb_clk);
            check_value($sformatf("owner %0d released out", v), 64'd0, 64'(io_out));
            check_value($sformatf("owner %0d released oeb", v), PIN_MASK, 64'(io_oeb));
        end
    endtask

    function automatic logic [31:0] unmapped_addr(input int k);
        case (k)
            0:       return 32'h4000_0000;
            1:       return `NEBULA_TEAM_BASE + 32'(NT) * `NEBULA_TEAM_STRIDE;
            default: return `NEBULA_SRAM_BASE + 32'(4 * `NEBULA_SRAM_WORDS);
        endcase
    endfunction

    // Registers that an aliased unmapped write would hit first
    function automatic logic [31:0] probe_addr(input int p);
        case (p)
            0:       return sram_addr(0);
            1:       return `NEBULA_GPIO_BASE;
            2:       return team_addr(0, nebula_pkg::REG_OUT);
            default: return team_addr(0, nebula_pkg::REG_OEB);
        endcase
    endfunction

    task automatic test_unmapped();
        logic [31:0] expect_v [4];
        logic [31:0] rd;
        for (int k = 0; k < 3; k++) begin
            wb_read(unmapped_addr(k), rd);
            check_value($sformatf("unmapped %0d read", k), 64'(`NEBULA_FILL_WORD), 64'(rd));
            // Load known contents into every probed register
            for (int p = 0; p < 4; p++) begin
                rand_word   = lcg_step(rand_word);
                expect_v[p] = (p == 1) ? 32'(k) : rand_word; // Owner takes a slot index
                wb_write(probe_addr(p), expect_v[p], 4'hF);
            end
            rand_word = lcg_step(rand_word);
            wb_write(unmapped_addr(k), rand_word, 4'hF);
            for (int p = 0; p < 4; p++) begin
                wb_read(probe_addr(p), rd);
                check_value($sformatf("unmapped %0d write probe %0d", k, p),
                            64'(expect_v[p]), 64'(rd));
            end
        end
    endtask

    initial begin
        rst         <= 1'b1;
        wbs_cyc     <= 1'b0;
        wbs_stb     <= 1'b0;
        wbs_we      <= 1'b0;
        wbs_sel     <= '0;
        wbs_adr     <= '0;
        wbs_dat_w   <= '0;
        error_count = 0;
        check_count = 0;
        rand_word   = 32'h1588_4465;
        repeat (16) @(posedge wb_clk);
        rst <= 1'b0;
        test_reset_state();
        test_sram();
        test_team_slots();
        test_gpio_routing();
        test_unmapped();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: nebula_top.sv
// Top level of the multi-project fabric
// Host Wishbone port to the SRAM, the team slots and the pin owner control
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module nebula_top (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  logic                wbs_cyc_i,
    input  logic                wbs_stb_i,
    input  logic                wbs_we_i,
    input  nebula_pkg::sel_t    wbs_sel_i,
    input  nebula_pkg::word_t   wbs_adr_i,
    input  nebula_pkg::word_t   wbs_dat_i,
    output logic                wbs_ack_o,
    output nebula_pkg::word_t   wbs_dat_o,
    output nebula_pkg::pins_t   io_out_o,
    output nebula_pkg::pins_t   io_oeb_o
);

    logic                         sram_stb;
    logic                         sram_ack;
    nebula_pkg::word_t            sram_dat;
    logic                         gpio_stb;
    logic                         gpio_ack;
    nebula_pkg::word_t            gpio_dat;
    logic [`NEBULA_NUM_TEAMS-1:0] team_stb;
    logic [`NEBULA_NUM_TEAMS-1:0] team_ack;
    nebula_pkg::word_t            team_dat [`NEBULA_NUM_TEAMS];
    nebula_pkg::pins_t            team_out [`NEBULA_NUM_TEAMS];  // Pins per slot
    nebula_pkg::pins_t            team_oeb [`NEBULA_NUM_TEAMS];

    wb_decoder i_decoder (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_adr_i  (wbs_adr_i),
        .sram_stb_o (sram_stb),
        .gpio_stb_o (gpio_stb),
        .team_stb_o (team_stb),
        .sram_ack_i (sram_ack),
        .gpio_ack_i (gpio_ack),
        .team_ack_i (team_ack),
        .sram_dat_i (sram_dat),
        .gpio_dat_i (gpio_dat),
        .team_dat_i (team_dat),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o)
    );

    // One slot per team, each tagged with its index
    for (genvar g = 0; g < `NEBULA_NUM_TEAMS; g++) begin : g_team
        team_slot #(
            .TEAM_INDEX (g)
        ) i_team_slot (
            .wb_clk_i   (wb_clk_i),
            .rst_i      (rst_i),
            .stb_i      (team_stb[g]),
            .we_i       (wbs_we_i),
            .sel_i      (wbs_sel_i),
            .adr_i      (wbs_adr_i),
            .dat_i      (wbs_dat_i),
            .ack_o      (team_ack[g]),
            .dat_o      (team_dat[g]),
            .gpio_out_o (team_out[g]),
            .gpio_oeb_o (team_oeb[g])
        );
    end

    gpio_control i_gpio_control (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .stb_i      (gpio_stb),
        .we_i       (wbs_we_i),
        .adr_i      (wbs_adr_i),
        .dat_i      (wbs_dat_i),
        .ack_o      (gpio_ack),
        .dat_o      (gpio_dat),
        .team_out_i (team_out),
        .team_oeb_i (team_oeb),
        .io_out_o   (io_out_o),
        .io_oeb_o   (io_oeb_o)
    );

    wb_sram i_sram (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .stb_i    (sram_stb),
        .we_i     (wbs_we_i),
        .sel_i    (wbs_sel_i),
        .adr_i    (wbs_adr_i),
        .dat_i    (wbs_dat_i),
        .ack_o    (sram_ack),
        .dat_o    (sram_dat)
    );

endmodule

`default_nettype wire

// File: wb_sram.sv
// Word SRAM on Wishbone
// Byte-select writes, registered read with a one-cycle ack
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module wb_sram (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::sel_t    sel_i,
    input  nebula_pkg::word_t   adr_i,
    input  nebula_pkg::word_t   dat_i,
    output logic                ack_o,
    output nebula_pkg::word_t   dat_o
);

    localparam int AW = $clog2(`NEBULA_SRAM_WORDS);

    nebula_pkg::word_t mem [`NEBULA_SRAM_WORDS];
    nebula_pkg::word_t dat_q;
    logic [AW-1:0]     idx;
    logic              ack_q;

    assign idx = adr_i[AW+1:2]; // Word address

    // Access on the first strobe cycle only
    always_ff @(posedge wb_clk_i) begin
        if (stb_i && !ack_q) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            dat_q <= mem[idx]; // Old contents on a write
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i && !ack_q;
        end
    end

    assign ack_o = ack_q;
    assign dat_o = dat_q;

    // No ack without a request in the cycle before
    a_ack_after_stb: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ack_o |-> $past(stb_i));

endmodule

`default_nettype wire

// File: gpio_control.sv
// GPIO control for the chip pins
// Owner register on Wishbone picks which team slot drives all pins
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module gpio_control (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::word_t   adr_i,
    input  nebula_pkg::word_t   dat_i,
    output logic                ack_o,
    output nebula_pkg::word_t   dat_o,
    input  nebula_pkg::pins_t   team_out_i [`NEBULA_NUM_TEAMS],
    input  nebula_pkg::pins_t   team_oeb_i [`NEBULA_NUM_TEAMS],
    output nebula_pkg::pins_t   io_out_o,
    output nebula_pkg::pins_t   io_oeb_o
);

    localparam int NT    = `NEBULA_NUM_TEAMS;
    localparam int IDX_W = (NT > 1) ? $clog2(NT) : 1;
    localparam int OWN_W = $clog2(NT + 1); // Room for the no-owner code

    logic [OWN_W-1:0] owner_q;
    logic             ack_q;
    logic             own_hit;

    assign own_hit = (adr_i[3:2] == 2'd0); // Owner sits at word offset 0

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q   <= 1'b0;
            owner_q <= OWN_W'(NT);   // No owner, pins released
        end else begin
            ack_q <= stb_i && !ack_q;
            if (stb_i && we_i && ack_q && own_hit) begin
                owner_q <= dat_i[OWN_W-1:0];
            end
        end
    end

    assign ack_o = ack_q;
    assign dat_o = own_hit ? nebula_pkg::word_t'(owner_q) : '0;

    // Out-of-range owner codes also release the pins
    always_comb begin
        io_out_o = '0;
        io_oeb_o = '1;
        if (owner_q < OWN_W'(NT)) begin
            io_out_o = team_out_i[owner_q[IDX_W-1:0]];
            io_oeb_o = team_oeb_i[owner_q[IDX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: team_slot.sv
// Team project slot standing in for a student design
// Pin output, active-low output enable and identity registers on Wishbone
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module team_slot #(
    parameter int TEAM_INDEX = 0
) (
    input  logic                wb_clk_i,
    input  logic                rst_i,
    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::sel_t    sel_i,
    input  nebula_pkg::word_t   adr_i,
    input  nebula_pkg::word_t   dat_i,
    output logic                ack_o,
    output nebula_pkg::word_t   dat_o,
    output nebula_pkg::pins_t   gpio_out_o,
    output nebula_pkg::pins_t   gpio_oeb_o
);

    nebula_pkg::team_reg_e reg_sel;
    nebula_pkg::pins_t     out_q;
    nebula_pkg::pins_t     oeb_q;
    nebula_pkg::pins_t     wr_mask;
    nebula_pkg::pins_t     wr_data;
    logic                  ack_q;
    logic                  wr_en;

    assign reg_sel = nebula_pkg::team_reg_e'(adr_i[3:2]);
    assign wr_data = nebula_pkg::pins_t'(dat_i); // Zero-extended to the pin width
    assign wr_en   = stb_i && we_i && ack_q;     // Commit on the ack edge

    // Pins above bit 31 have no byte lane and keep their reset value
    always_comb begin
        wr_mask = '0;
        for (int i = 0; i < 32; i++) begin
            wr_mask[i] = sel_i[i / 8];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            out_q <= '0;
            oeb_q <= '1;   // All pins start as inputs
        end else begin
            ack_q <= stb_i && !ack_q;
            if (wr_en && reg_sel == nebula_pkg::REG_OUT) begin
                out_q <= (out_q & ~wr_mask) | (wr_data & wr_mask);
            end
            if (wr_en && reg_sel == nebula_pkg::REG_OEB) begin
                oeb_q <= (oeb_q & ~wr_mask) | (wr_data & wr_mask);
            end
        end
    end

    always_comb begin
        case (reg_sel)
            nebula_pkg::REG_OUT: dat_o = nebula_pkg::word_t'(out_q);
            nebula_pkg::REG_OEB: dat_o = nebula_pkg::word_t'(oeb_q);
            nebula_pkg::REG_ID:  dat_o = `NEBULA_TEAM_ID_TAG | {24'd0, 8'(TEAM_INDEX)};
            default:             dat_o = '0;
        endcase
    end

    assign ack_o      = ack_q;
    assign gpio_out_o = out_q;
    assign gpio_oeb_o = oeb_q;

    // One ack per request, even with the strobe still up
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: wb_decoder.sv
// Wishbone address decoder for the fabric
// Qualifies one strobe per target, muxes read data, answers unmapped addresses
`default_nettype none
`timescale 1ns/10ps

`include "nebula_cfg.svh"

module wb_decoder (
    input  logic                          wb_clk_i,
    input  logic                          rst_i,
    input  logic                          wbs_cyc_i,
    input  logic                          wbs_stb_i,
    input  nebula_pkg::word_t             wbs_adr_i,
    output logic                          sram_stb_o,
    output logic                          gpio_stb_o,
    output logic [`NEBULA_NUM_TEAMS-1:0]  team_stb_o,
    input  logic                          sram_ack_i,
    input  logic                          gpio_ack_i,
    input  logic [`NEBULA_NUM_TEAMS-1:0]  team_ack_i,
    input  nebula_pkg::word_t             sram_dat_i,
    input  nebula_pkg::word_t             gpio_dat_i,
    input  nebula_pkg::word_t             team_dat_i [`NEBULA_NUM_TEAMS],
    output logic                          wbs_ack_o,
    output nebula_pkg::word_t             wbs_dat_o
);

    localparam int NT         = `NEBULA_NUM_TEAMS;
    localparam int IDX_W      = (NT > 1) ? $clog2(NT) : 1;
    localparam int STRIDE_LSB = $clog2(`NEBULA_TEAM_STRIDE);

    nebula_pkg::word_t   region;
    nebula_pkg::word_t   offset;
    nebula_pkg::target_e tgt;
    logic [IDX_W-1:0]    team_idx;
    logic                req;
    logic                none_stb;
    logic                none_ack;

    // Region compare plus bounds check inside the region
    always_comb begin
        region   = wbs_adr_i & `NEBULA_REGION_MASK;
        offset   = wbs_adr_i & ~`NEBULA_REGION_MASK;
        team_idx = IDX_W'(offset >> STRIDE_LSB);
        if (region == `NEBULA_SRAM_BASE && offset < 4 * `NEBULA_SRAM_WORDS) begin
            tgt = nebula_pkg::TGT_SRAM;
        end else if (region == `NEBULA_GPIO_BASE) begin
            tgt = nebula_pkg::TGT_GPIO;
        end else if (region == `NEBULA_TEAM_BASE && offset < NT * `NEBULA_TEAM_STRIDE) begin
            tgt = nebula_pkg::TGT_TEAM;
        end else begin
            tgt = nebula_pkg::TGT_NONE; // Nobody owns it
        end
    end

    assign req        = wbs_cyc_i & wbs_stb_i;
    assign sram_stb_o = req && (tgt == nebula_pkg::TGT_SRAM);
    assign gpio_stb_o = req && (tgt == nebula_pkg::TGT_GPIO);
    assign none_stb   = req && (tgt == nebula_pkg::TGT_NONE);

    always_comb begin
        team_stb_o = '0;
        if (req && tgt == nebula_pkg::TGT_TEAM) begin
            team_stb_o[team_idx] = 1'b1;
        end
    end

    // Local responder so unmapped cycles still terminate
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= none_stb && !none_ack;
        end
    end

    assign wbs_ack_o = sram_ack_i | gpio_ack_i | (|team_ack_i) | none_ack;

    // Address is held until ack, so the mux can follow it directly
    always_comb begin
        case (tgt)
            nebula_pkg::TGT_SRAM: wbs_dat_o = sram_dat_i;
            nebula_pkg::TGT_GPIO: wbs_dat_o = gpio_dat_i;
            nebula_pkg::TGT_TEAM: wbs_dat_o = team_dat_i[team_idx];
            default:              wbs_dat_o = `NEBULA_FILL_WORD;
        endcase
    end

    // At most one target sees a strobe, the local responder included
    a_stb_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0({sram_stb_o, gpio_stb_o, team_stb_o, none_stb}));

endmodule

`default_nettype wire

// File: nebula_pkg.sv
// Shared types of the fabric
// Bus words, pin vectors, decoder targets and slot register selects
`default_nettype none

`include "nebula_cfg.svh"

package nebula_pkg;

    // Wishbone data and address word
    typedef logic [31:0] word_t;

    typedef logic [3:0] sel_t; // One bit per byte lane

    // Chip pin vector
    typedef logic [`NEBULA_GPIO_W-1:0] pins_t;

    // Targets seen by the address decoder
    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_GPIO,
        TGT_TEAM,
        TGT_NONE
    } target_e;

    // Slot registers, taken from address bits 3:2
    typedef enum logic [1:0] {
        REG_OUT = 2'd0,
        REG_OEB = 2'd1,
        REG_ID  = 2'd2
    } team_reg_e;

endpackage

`default_nettype wire

// File: nebula_cfg.svh
// Fabric configuration for the multi-project chip
// Team count, pin width, address map and fixed read words

`ifndef NEBULA_CFG_SVH
`define NEBULA_CFG_SVH

// Team project slots behind the decoder
`define NEBULA_NUM_TEAMS 4

// Chip pin bus
`define NEBULA_GPIO_W 38

// Region bases, compared under the region mask
`define NEBULA_SRAM_BASE 32'h3000_0000
`define NEBULA_GPIO_BASE 32'h3100_0000
`define NEBULA_TEAM_BASE 32'h3200_0000

// Address span of one team slot
`define NEBULA_TEAM_STRIDE 32'h0000_0100

`define NEBULA_REGION_MASK 32'hFF00_0000 // Upper byte picks the region

// SRAM depth in 32-bit words
`define NEBULA_SRAM_WORDS 256

`define NEBULA_FILL_WORD 32'hDEAD_0BAD   // Returned for unmapped reads

// Identity word of a slot, index goes in the low byte
`define NEBULA_TEAM_ID_TAG 32'h7EA0_0000

`endif
